//--- trap_defs.svh
// Widths are fixed by the page-table layout and ring model, so changing them needs matching RTL
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// Page-table permission field, page bits 15 to 9
`define TRAP_PT_W 7

// Current and page ring number
`define TRAP_RING_W 2

// Encoded trap cause
`define TRAP_CAUSE_W 3

// Input sample to brk, trap and cause
// One stage in the checkers, one in the combiner
`define TRAP_LATENCY 2

`endif

//--- trap_pkg.sv
// Shared types and cause codes, where a lower nonzero code wins in the combiner's priority
`include "trap_defs.svh"

package trap_pkg;

  // Bit 6 write permit, 5 read permit, 4 fetch permit
  // Bit 3 write-in-page-table, 2 page used, 1:0 page ring
  typedef logic [`TRAP_PT_W-1:0] pt_bits_t;

  typedef logic [`TRAP_RING_W-1:0] ring_t;  // Higher number is more privileged

  typedef logic [`TRAP_CAUSE_W-1:0] cause_t;

  localparam cause_t cause_none       = 3'd0;  // No trap this cycle
  localparam cause_t cause_page_fault = 3'd1;  // Page not mapped
  localparam cause_t cause_ring       = 3'd2;  // Page ring above cur_ring
  localparam cause_t cause_perm       = 3'd3;  // Includes page-table write
  localparam cause_t cause_vec_trap   = 3'd4;
  localparam cause_t cause_fetch_trap = 3'd5;
  localparam cause_t cause_intr       = 3'd6;  // Taken on instruction fetch
  localparam cause_t cause_ext        = 3'd7;  // Only cause left under inhibit

endpackage

//--- prot_if.sv
// Registered protection flags, valid one cycle after the access was sampled
`timescale 1ns/100ps

interface prot_if;

  logic page_fault;  // No permit bit set
  logic ring_viol;   // Page ring above current ring
  logic perm_viol;   // Write, fetch or read without permit
  logic pt_write;    // Write to a page-table page

  modport src (
    output page_fault,
    output ring_viol,
    output perm_viol,
    output pt_write
  );

  modport dst (
    input page_fault,
    input ring_viol,
    input perm_viol,
    input pt_write
  );

endinterface

//--- evt_if.sv
// Registered event flags, valid one cycle after the access was sampled
`timescale 1ns/100ps

interface evt_if;

  logic intr;        // Interrupt on fetch
  logic fetch_trap;  // Fetch trap on fetch
  logic vec_trap;    // Vector trap on any valid access
  logic ext_trap;    // Not qualified by acc_valid

  modport src (
    output intr,
    output fetch_trap,
    output vec_trap,
    output ext_trap
  );

  modport dst (
    input intr,
    input fetch_trap,
    input vec_trap,
    input ext_trap
  );

endinterface

//--- prot_check.sv
// Page-used bit (pt_bits[2]) is not checked, and an indirect access always counts as a read
`timescale 1ns/100ps

module prot_check (
  input  logic               clk,
  input  logic               reset,
  input  logic               acc_valid,
  input  logic               acc_fetch,
  input  logic               acc_write,
  input  logic               acc_indirect,
  input  trap_pkg::pt_bits_t pt_bits,
  input  trap_pkg::ring_t    cur_ring,
  prot_if.src                prot
);

  import trap_pkg::*;

  logic  wr_permit;
  logic  rd_permit;
  logic  fx_permit;
  logic  wip_flag;
  ring_t page_ring;
  logic  non_fetch_rd;
  logic  pf_d;
  logic  rv_d;
  logic  pv_d;
  logic  ptw_d;

  assign wr_permit = pt_bits[6];    // Write permit
  assign rd_permit = pt_bits[5];    // Read permit
  assign fx_permit = pt_bits[4];    // Fetch permit
  assign wip_flag  = pt_bits[3];    // Page holds page tables
  assign page_ring = pt_bits[1:0];

  // Data read, or pointer read of an indirect access
  assign non_fetch_rd = ~acc_fetch & (acc_indirect | ~acc_write);

  assign pf_d = acc_valid & ~wr_permit & ~rd_permit & ~fx_permit;  // Unmapped page

  assign rv_d = acc_valid & ~pf_d & (page_ring > cur_ring);  // Needs more privilege

  always_comb begin
    pv_d = 1'b0;
    if (acc_valid && !pf_d && !rv_d) begin
      pv_d = (acc_write & ~wr_permit) |
             (acc_fetch & ~fx_permit) |
             (non_fetch_rd & ~rd_permit);
    end
  end

  // Kept apart so the combiner can fold it into the permission class
  assign ptw_d = acc_valid & ~pf_d & ~rv_d & acc_write & wip_flag;

  always_ff @(posedge clk) begin
    if (reset) begin
      prot.page_fault <= 1'b0;
      prot.ring_viol  <= 1'b0;
      prot.perm_viol  <= 1'b0;
      prot.pt_write   <= 1'b0;
    end else begin
      prot.page_fault <= pf_d;
      prot.ring_viol  <= rv_d;
      prot.perm_viol  <= pv_d;
      prot.pt_write   <= ptw_d;
    end
  end

  // At most one protection class per access, so the cause code is never ambiguous
  a_prot_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({prot.page_fault, prot.ring_viol, prot.perm_viol})
  );

endmodule

//--- event_detect.sv
// Event inputs are levels sampled every cycle, and ext_trap is taken even without a valid access
`timescale 1ns/100ps

module event_detect (
  input  logic clk,
  input  logic reset,
  input  logic acc_valid,
  input  logic acc_fetch,
  input  logic int_req,
  input  logic fetch_trap,
  input  logic vec_trap,
  input  logic ext_trap,
  evt_if.src   evt
);

  logic valid_fetch;
  logic intr_d;
  logic ftrap_d;
  logic vtrap_d;

  assign valid_fetch = acc_valid & acc_fetch;

  assign intr_d  = valid_fetch & int_req;     // Interrupt taken between instructions
  assign ftrap_d = valid_fetch & fetch_trap;  // Single-step style trap
  assign vtrap_d = acc_valid & vec_trap;

  always_ff @(posedge clk) begin
    if (reset) begin
      evt.intr       <= 1'b0;
      evt.fetch_trap <= 1'b0;
      evt.vec_trap   <= 1'b0;
      evt.ext_trap   <= 1'b0;
    end else begin
      evt.intr       <= intr_d;
      evt.fetch_trap <= ftrap_d;
      evt.vec_trap   <= vtrap_d;
      evt.ext_trap   <= ext_trap;  // Raw level
    end
  end

  // Fetch-qualified events must trace back to a valid fetch one cycle earlier
  a_fetch_events: assert property (
    @(posedge clk) disable iff (reset)
    (evt.intr || evt.fetch_trap) |-> $past(acc_valid && acc_fetch)
  );

endmodule

//--- brk_combine.sv
// Page-table write protection is always enabled, so pt_write always counts as a permission fault
`timescale 1ns/100ps

module brk_combine (
  input  logic             clk,
  input  logic             reset,
  input  logic             brk_inhibit,
  prot_if.dst              prot,
  evt_if.dst               evt,
  output logic             brk,
  output logic             trap,
  output trap_pkg::cause_t cause
);

  import trap_pkg::*;

  logic   inhibit_q;
  logic   perm_any;
  logic   brk_src;
  logic   brk_d;
  logic   trap_d;
  cause_t cause_d;

  // Lines inhibit up with the checker outputs
  always_ff @(posedge clk) begin
    if (reset) begin
      inhibit_q <= 1'b0;
    end else begin
      inhibit_q <= brk_inhibit;
    end
  end

  assign perm_any = prot.perm_viol | prot.pt_write;

  assign brk_src = prot.page_fault | prot.ring_viol | perm_any |
                   evt.intr | evt.fetch_trap | evt.vec_trap;

  assign brk_d  = brk_src & ~inhibit_q;   // Inhibit masks every break source
  assign trap_d = brk_d | evt.ext_trap;   // External trap bypasses inhibit

  always_comb begin
    cause_d = cause_none;
    if (!inhibit_q && prot.page_fault) begin
      cause_d = cause_page_fault;
    end else if (!inhibit_q && prot.ring_viol) begin
      cause_d = cause_ring;
    end else if (!inhibit_q && perm_any) begin
      cause_d = cause_perm;
    end else if (!inhibit_q && evt.vec_trap) begin
      cause_d = cause_vec_trap;
    end else if (!inhibit_q && evt.fetch_trap) begin
      cause_d = cause_fetch_trap;
    end else if (!inhibit_q && evt.intr) begin
      cause_d = cause_intr;
    end else if (evt.ext_trap) begin
      cause_d = cause_ext;  // Lowest priority
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      brk   <= 1'b0;
      trap  <= 1'b0;
      cause <= cause_none;
    end else begin
      brk   <= brk_d;
      trap  <= trap_d;
      cause <= cause_d;
    end
  end

  a_brk_trap: assert property (
    @(posedge clk) disable iff (reset)
    brk |-> trap
  );

  // A code is reported for every trap and only for a trap
  a_cause_trap: assert property (
    @(posedge clk) disable iff (reset)
    (cause == cause_none) == !trap
  );

endmodule

//--- trap_detect.sv
// Results appear TRAP_LATENCY cycles after the inputs, one access per cycle with no back-pressure
`timescale 1ns/100ps
`include "trap_defs.svh"

module trap_detect (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     acc_valid,
  input  logic                     acc_fetch,
  input  logic                     acc_write,
  input  logic                     acc_indirect,
  input  logic [`TRAP_PT_W-1:0]    pt_bits,   // Page bits 15 to 9
  input  logic [`TRAP_RING_W-1:0]  cur_ring,
  input  logic                     int_req,
  input  logic                     fetch_trap,
  input  logic                     vec_trap,
  input  logic                     ext_trap,
  input  logic                     brk_inhibit,
  output logic                     brk,
  output logic                     trap,
  output logic [`TRAP_CAUSE_W-1:0] cause
);

  prot_if prot_bus ();  // Checker to combiner
  evt_if  evt_bus ();   // Detector to combiner

  prot_check u_prot_check (
    .clk          (clk),
    .reset        (reset),
    .acc_valid    (acc_valid),
    .acc_fetch    (acc_fetch),
    .acc_write    (acc_write),
    .acc_indirect (acc_indirect),
    .pt_bits      (pt_bits),
    .cur_ring     (cur_ring),
    .prot         (prot_bus.src)
  );

  event_detect u_event_detect (
    .clk        (clk),
    .reset      (reset),
    .acc_valid  (acc_valid),
    .acc_fetch  (acc_fetch),
    .int_req    (int_req),
    .fetch_trap (fetch_trap),
    .vec_trap   (vec_trap),
    .ext_trap   (ext_trap),
    .evt        (evt_bus.src)
  );

  brk_combine u_brk_combine (
    .clk         (clk),
    .reset       (reset),
    .brk_inhibit (brk_inhibit),  // Delayed inside to match the data
    .prot        (prot_bus.dst),
    .evt         (evt_bus.dst),
    .brk         (brk),
    .trap        (trap),
    .cause       (cause)
  );

endmodule

//--- tb_clkgen.sv
// Free-running 4 ns clock, reset held high for RESET_CYCLES rising edges and then released
`timescale 1ns/100ps

module tb_clkgen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;  // 50 percent duty
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;  // Released on an edge like all other inputs
  end

endmodule

//--- tb_trap_detect.sv
// Table rows, then seeded random rows, each checked TRAP_LATENCY cycles after it is driven
`timescale 1ns/100ps
`include "trap_defs.svh"

module tb_trap_detect;

  import trap_pkg::*;

  localparam int NUM_RAND     = 200;
  localparam int RESET_CYCLES = 10;

  typedef logic [3:0] acc_t;  // valid, fetch, write, indirect
  typedef logic [4:0] evt_t;  // int_req, fetch_trap, vec_trap, ext_trap, brk_inhibit
  typedef logic [`TRAP_CAUSE_W+1:0] res_t;  // brk, trap, cause
  typedef logic [4+`TRAP_PT_W+`TRAP_RING_W+5-1:0] stim_t;  // acc, pt_bits, cur_ring, evt

  logic     clk;
  logic     reset;
  logic     acc_valid;
  logic     acc_fetch;
  logic     acc_write;
  logic     acc_indirect;
  pt_bits_t pt_bits;
  ring_t    cur_ring;
  logic     int_req;
  logic     fetch_trap;
  logic     vec_trap;
  logic     ext_trap;
  logic     brk_inhibit;
  logic     brk;
  logic     trap;
  cause_t   cause;

  string  tbl_name[$];   // Hand-worked rows
  stim_t  tbl_stim[$];
  res_t   tbl_exp[$];
  string  pipe_name[$];  // Rows still in flight
  res_t   pipe_exp[$];
  int     err_cnt     = 0;
  int     chk_cnt     = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 1000;  // Replaced once the table is built
  integer seed        = 32'hdbcfa71d;

  tb_clkgen #(.PERIOD_NS(4.0), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
    .clk   (clk),
    .reset (reset)
  );

  trap_detect UUT (
    .clk          (clk),
    .reset        (reset),
    .acc_valid    (acc_valid),
    .acc_fetch    (acc_fetch),
    .acc_write    (acc_write),
    .acc_indirect (acc_indirect),
    .pt_bits      (pt_bits),
    .cur_ring     (cur_ring),
    .int_req      (int_req),
    .fetch_trap   (fetch_trap),
    .vec_trap     (vec_trap),
    .ext_trap     (ext_trap),
    .brk_inhibit  (brk_inhibit),
    .brk          (brk),
    .trap         (trap),
    .cause        (cause)
  );

  // Expected result from the protection and event rules
  function automatic res_t ref_result(input stim_t s);
    acc_t     a;
    pt_bits_t pt;
    ring_t    ring;
    evt_t     ev;
    logic     pf;
    logic     rv;
    logic     pv;
    logic     intr;
    logic     ftr;
    logic     vtr;
    logic     brk_e;
    logic     trap_e;
    cause_t   c;
    {a, pt, ring, ev} = s;
    pf = a[3] && (pt[6:4] == 3'b000);      // No permit at all
    rv = a[3] && !pf && (pt[1:0] > ring);  // Page needs more privilege
    pv = a[3] && !pf && !rv &&
         ((a[1] && !pt[6]) || (a[2] && !pt[4]) ||
          (!a[2] && (a[0] || !a[1]) && !pt[5]) || (a[1] && pt[3]));
    intr   = a[3] && a[2] && ev[4];
    ftr    = a[3] && a[2] && ev[3];
    vtr    = a[3] && ev[2];
    brk_e  = !ev[0] && (pf || rv || pv || intr || ftr || vtr);
    trap_e = brk_e || ev[1];
    if (brk_e) begin
      if (pf)        c = cause_page_fault;
      else if (rv)   c = cause_ring;
      else if (pv)   c = cause_perm;
      else if (vtr)  c = cause_vec_trap;
      else if (ftr)  c = cause_fetch_trap;
      else           c = cause_intr;
    end else if (trap_e) begin
      c = cause_ext;  // Only source left under inhibit
    end else begin
      c = cause_none;
    end
    return {brk_e, trap_e, c};
  endfunction

  task automatic add_row(input string name, input acc_t acc, input pt_bits_t pt,
                         input ring_t ring, input evt_t ev, input res_t exp);
    tbl_name.push_back(name);
    tbl_stim.push_back({acc, pt, ring, ev});
    tbl_exp.push_back(exp);
  endtask

  // pt: W R F WIP used ring[1:0], ev: ir ft vt et inh
  task automatic build_table();
    add_row("idle",           4'b0000, 7'b0000000, 2'd0, 5'b00000, {2'b00, cause_none});
    add_row("idle_events",    4'b0000, 7'b0000000, 2'd0, 5'b11100, {2'b00, cause_none});
    add_row("read_ok",        4'b1000, 7'b1110100, 2'd0, 5'b00000, {2'b00, cause_none});
    add_row("fetch_ok",       4'b1100, 7'b1110100, 2'd0, 5'b00000, {2'b00, cause_none});
    add_row("write_ok",       4'b1010, 7'b1110100, 2'd0, 5'b00000, {2'b00, cause_none});
    add_row("page_fault",     4'b1000, 7'b0000100, 2'd0, 5'b00000, {2'b11, cause_page_fault});
    add_row("ring_viol",      4'b1000, 7'b1110110, 2'd1, 5'b00000, {2'b11, cause_ring});
    add_row("ring_ok",        4'b1000, 7'b1110110, 2'd3, 5'b00000, {2'b00, cause_none});
    add_row("write_no_perm",  4'b1010, 7'b0110100, 2'd0, 5'b00000, {2'b11, cause_perm});
    add_row("fetch_no_perm",  4'b1100, 7'b1100100, 2'd0, 5'b00000, {2'b11, cause_perm});
    add_row("read_no_perm",   4'b1000, 7'b1010100, 2'd0, 5'b00000, {2'b11, cause_perm});
    add_row("indir_no_perm",  4'b1011, 7'b1010100, 2'd0, 5'b00000, {2'b11, cause_perm});
    add_row("pt_write",       4'b1010, 7'b1111100, 2'd0, 5'b00000, {2'b11, cause_perm});
    add_row("pt_read_ok",     4'b1000, 7'b1111100, 2'd0, 5'b00000, {2'b00, cause_none});
    add_row("intr",           4'b1100, 7'b1110100, 2'd0, 5'b10000, {2'b11, cause_intr});
    add_row("fetch_trap",     4'b1100, 7'b1110100, 2'd0, 5'b01000, {2'b11, cause_fetch_trap});
    add_row("vec_trap",       4'b1000, 7'b1110100, 2'd0, 5'b00100, {2'b11, cause_vec_trap});
    add_row("ext_only",       4'b0000, 7'b0000000, 2'd0, 5'b00010, {2'b01, cause_ext});
    add_row("intr_on_read",   4'b1000, 7'b1110100, 2'd0, 5'b11000, {2'b00, cause_none});
    add_row("pf_and_intr",    4'b1100, 7'b0000100, 2'd0, 5'b10000, {2'b11, cause_page_fault});
    add_row("ring_and_vec",   4'b1000, 7'b1110110, 2'd1, 5'b00100, {2'b11, cause_ring});
    add_row("perm_and_ftrap", 4'b1100, 7'b1100100, 2'd0, 5'b01100, {2'b11, cause_perm});
    add_row("vec_ftrap_intr", 4'b1100, 7'b1110100, 2'd0, 5'b11110, {2'b11, cause_vec_trap});
    add_row("ftrap_and_intr", 4'b1100, 7'b1110100, 2'd0, 5'b11000, {2'b11, cause_fetch_trap});
    add_row("inhibit_pf",     4'b1000, 7'b0000100, 2'd0, 5'b00001, {2'b00, cause_none});
    add_row("inhibit_events", 4'b1100, 7'b1110100, 2'd0, 5'b11101, {2'b00, cause_none});
    add_row("inhibit_ext",    4'b1000, 7'b0000100, 2'd0, 5'b00011, {2'b01, cause_ext});
  endtask

  task automatic check_result(input string name, input res_t exp);
    chk_cnt++;
    if ({brk, trap, cause} !== exp) begin
      err_cnt++;
      $display("Fail %s: expected brk=%b trap=%b cause=%0d, actual brk=%b trap=%b cause=%0d",
               name, exp[4], exp[3], exp[2:0], brk, trap, cause);
    end
  endtask

  // One cycle: drive on the rising edge, compare the oldest row on the falling edge
  task automatic apply_row(input string name, input stim_t s, input res_t exp);
    @(posedge clk);
    {acc_valid, acc_fetch, acc_write, acc_indirect, pt_bits, cur_ring,
     int_req, fetch_trap, vec_trap, ext_trap, brk_inhibit} <= s;
    pipe_name.push_back(name);
    pipe_exp.push_back(exp);
    @(negedge clk);
    if (pipe_exp.size() > `TRAP_LATENCY) begin
      check_result(pipe_name.pop_front(), pipe_exp.pop_front());
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    stim_t s;
    {acc_valid, acc_fetch, acc_write, acc_indirect, pt_bits, cur_ring,
     int_req, fetch_trap, vec_trap, ext_trap, brk_inhibit} = '0;
    acc_valid = 1'b1;  // Page fault and external trap held through reset
    ext_trap  = 1'b1;
    build_table();
    cycle_limit = RESET_CYCLES + tbl_stim.size() + NUM_RAND + `TRAP_LATENCY + 20;
    repeat (`TRAP_LATENCY + 1) @(posedge clk);
    @(negedge clk);
    check_result("in_reset", '0);  // Trap sources present, outputs held clear
    while (reset !== 1'b0) @(posedge clk);
    @(negedge clk);
    check_result("reset", '0);  // Outputs cleared by reset
    foreach (tbl_stim[i]) begin
      apply_row(tbl_name[i], tbl_stim[i], tbl_exp[i]);
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      s = $random(seed);  // Truncated to the stimulus width
      apply_row($sformatf("rand_%0d", i), s, ref_result(s));
    end
    repeat (`TRAP_LATENCY) apply_row("drain", '0, '0);  // Flush the last rows
    $display("Errors: %0d in %0d checks", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
trap_pkg.sv
prot_if.sv
evt_if.sv
prot_check.sv
event_detect.sv
brk_combine.sv
trap_detect.sv
tb_clkgen.sv
tb_trap_detect.sv

//--- Bender.yml
package:
  name: trap_detect

export_include_dirs:
  - .

sources:
  - files:
      - trap_pkg.sv
      - prot_if.sv
      - evt_if.sv
      - prot_check.sv
      - event_detect.sv
      - brk_combine.sv
      - trap_detect.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_trap_detect.sv
